//--- vlog.f
+incdir+include
design/fifo_pkg.sv
design/fifo_mem.sv
design/fifo_wr_ctrl.sv
design/fifo_rd_ctrl.sv
design/async_fifo.sv
verif/async_fifo_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the async FIFO testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns -f vlog.f \
    --top-module async_fifo_tb || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vasync_fifo_tb 2>&1)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- include/fifo_tb_checks.svh
`ifndef FIFO_TB_CHECKS_SVH
`define FIFO_TB_CHECKS_SVH

// ******************************
// fail path
// ******************************

// fail line, then stop the run
task automatic stop_on_mismatch();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on first mismatch");
endtask

// ******************************
// typed compares
// ******************************

// one data word against the model head
task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
        $display("ERROR at %0t ns: %s", $time, what);
        $display("  data got %0h expected %0h", got, exp);
        stop_on_mismatch();
    end
endtask

// whole write status
// fill is printed in decimal, it can reach FIFO_DEPTH
task automatic check_wstatus(input wr_status_t got, input wr_status_t exp,
                             input string what);
    if (got !== exp) begin
        $display("ERROR at %0t ns: %s", $time, what);
        $display("  wstatus got full=%b afull=%b fill=%0d", got.full,
                 got.almost_full, got.fill);
        $display("  expected    full=%b afull=%b fill=%0d", exp.full,
                 exp.almost_full, exp.fill);
        stop_on_mismatch();
    end
endtask

// whole read status
task automatic check_rstatus(input rd_status_t got, input rd_status_t exp,
                             input string what);
    if (got !== exp) begin
        $display("ERROR at %0t ns: %s", $time, what);
        $display("  rstatus got empty=%b aempty=%b fill=%0d", got.empty,
                 got.almost_empty, got.fill);
        $display("  expected    empty=%b aempty=%b fill=%0d", exp.empty,
                 exp.almost_empty, exp.fill);
        stop_on_mismatch();
    end
endtask

`endif

//--- verif/async_fifo_tb.sv
`timescale 1ns/1ns

module async_fifo_tb
    import fifo_pkg::*;
();

    localparam int AF_OFFSET    = 2;
    localparam int AE_OFFSET    = 2;
    // traffic profile changes every PHASE_NS
    localparam int PHASE_NS     = 240;
    localparam int WR_CYCLES    = 480;
    // read side emptying the FIFO at the end
    localparam int DRAIN_CYCLES = 100;
    localparam int CYCLE_LIMIT  = 2 * (3 + WR_CYCLES + DRAIN_CYCLES);

    logic       i_wclk;
    logic       i_wrstn;
    logic       i_wr;
    data_t      i_wdata;
    logic       i_rclk;
    logic       i_rrstn;
    logic       i_rd;
    wr_status_t o_wstatus;
    data_t      o_rdata;
    rd_status_t o_rstatus;

    // reference queue, one entry per accepted write
    data_t model [$];
    int    wr_total;
    int    rd_total;
    logic  wr_done;
    int    wclk_cycles = 0;

    `include "fifo_tb_checks.svh"

    async_fifo #(
        .ALMOST_FULL_OFFSET  (AF_OFFSET),
        .ALMOST_EMPTY_OFFSET (AE_OFFSET)
    ) UUT (
        .i_wclk    (i_wclk),
        .i_wrstn   (i_wrstn),
        .i_wr      (i_wr),
        .i_wdata   (i_wdata),
        .o_wstatus (o_wstatus),
        .i_rclk    (i_rclk),
        .i_rrstn   (i_rrstn),
        .i_rd      (i_rd),
        .o_rdata   (o_rdata),
        .o_rstatus (o_rstatus)
    );

    // unrelated clocks, 4 ns and 6 ns
    always #2 i_wclk = ~i_wclk;
    always #3 i_rclk = ~i_rclk;

    always @(posedge i_wclk) begin
        wclk_cycles++;
        if (wclk_cycles >= CYCLE_LIMIT) begin
            $display("timeout: traffic still running after %0d write clock cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ******************************
    // expected values
    // ******************************

    // write fill may run ahead of the model, never behind it
    function automatic wr_status_t expected_wstatus(input ptr_t got_fill, input int count);
        wr_status_t want;
        int         fill;
        fill = int'(got_fill);
        if (fill < count) begin
            fill = count;
        end
        if (fill > FIFO_DEPTH) begin
            fill = FIFO_DEPTH;
        end
        want.fill        = ptr_t'(fill);
        want.full        = (fill == FIFO_DEPTH);
        want.almost_full = (fill >= FIFO_DEPTH - AF_OFFSET);
        return want;
    endfunction

    // read fill may lag the model, never lead it
    function automatic rd_status_t expected_rstatus(input ptr_t got_fill, input int count);
        rd_status_t want;
        int         fill;
        fill = int'(got_fill);
        if (fill > count) begin
            fill = count;
        end
        want.fill         = ptr_t'(fill);
        want.empty        = (fill == 0);
        want.almost_empty = (fill <= AE_OFFSET);
        return want;
    endfunction

    function automatic int traffic_phase();
        return int'(($time / PHASE_NS) % 4);
    endfunction

    // percent chance of a strobe per cycle
    // phase 0 fills, 1 drains, 2 drifts up, 3 runs both flat out
    function automatic int write_pct(input int phase);
        case (phase)
            0:       return 90;
            1:       return 25;
            2:       return 60;
            default: return 100;
        endcase
    endfunction

    function automatic int read_pct(input int phase);
        case (phase)
            0:       return 30;
            1:       return 95;
            2:       return 60;
            default: return 100;
        endcase
    endfunction

    // ******************************
    // traffic
    // ******************************

    task automatic run_writer();
        wr_status_t seen;
        logic       pending;
        seen    = o_wstatus;
        pending = 1'b0;
        for (int c = 0; c <= WR_CYCLES; c++) begin
            @(posedge i_wclk);
            #1;
            // taken at that edge if full was low ahead of it
            if (pending && !seen.full) begin
                model.push_back(i_wdata);
                wr_total++;
                pending = 1'b0;
            end
            check_wstatus(o_wstatus, expected_wstatus(o_wstatus.fill, model.size()),
                          "write status after a write clock edge");
            seen = o_wstatus;
            // a refused word stays on the bus until full clears
            if (c == WR_CYCLES) begin
                pending = 1'b0;
            end else if (!pending) begin
                pending = int'($urandom_range(99)) < write_pct(traffic_phase());
                if (pending) begin
                    i_wdata = data_t'($urandom);
                end
            end
            i_wr = pending;
        end
        wr_done = 1'b1;
    endtask

    task automatic run_reader();
        rd_status_t seen;
        logic       pending;
        seen    = o_rstatus;
        pending = 1'b0;
        while (!(wr_done && rd_total == wr_total)) begin
            @(posedge i_rclk);
            #1;
            if (pending && !seen.empty) begin
                void'(model.pop_front());
                rd_total++;
            end
            check_rstatus(o_rstatus, expected_rstatus(o_rstatus.fill, model.size()),
                          "read status after a read clock edge");
            seen = o_rstatus;
            // once the writer stops, read every cycle to drain
            pending = wr_done || (int'($urandom_range(99)) < read_pct(traffic_phase()));
            i_rd    = pending;
            // show-ahead word is stable until the next read edge
            if (pending && !seen.empty) begin
                check_data(o_rdata, model[0], "read data against the model head");
            end
        end
        i_rd = 1'b0;
    endtask

    initial begin
        void'($urandom(2933));
        i_wclk   = 1'b0;
        i_rclk   = 1'b0;
        i_wrstn  = 1'b0;
        i_rrstn  = 1'b0;
        i_wr     = 1'b0;
        i_rd     = 1'b0;
        i_wdata  = '0;
        wr_total = 0;
        rd_total = 0;
        wr_done  = 1'b0;
        // each side leaves reset on its own clock
        fork
            begin
                repeat (3) @(posedge i_wclk);
                #1;
                i_wrstn = 1'b1;
                check_wstatus(o_wstatus,
                              wr_status_t'{full: 1'b0, almost_full: 1'b1, fill: ptr_t'(0)},
                              "write status just after reset");
            end
            begin
                repeat (3) @(posedge i_rclk);
                #1;
                i_rrstn = 1'b1;
                check_rstatus(o_rstatus,
                              rd_status_t'{empty: 1'b1, almost_empty: 1'b1, fill: ptr_t'(0)},
                              "read status just after reset");
            end
        join
        fork
            run_writer();
            run_reader();
        join
        // last reads reach the write side a few write clocks later
        while (o_wstatus.fill != ptr_t'(0)) begin
            @(posedge i_wclk);
            #1;
            check_wstatus(o_wstatus, expected_wstatus(o_wstatus.fill, model.size()),
                          "write status during the final drain");
        end
        check_rstatus(o_rstatus,
                      rd_status_t'{empty: 1'b1, almost_empty: 1'b1, fill: ptr_t'(0)},
                      "read status after the final drain");
        $display("%0d words written and read back", wr_total);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- design/async_fifo.sv
`timescale 1ns/1ns

module async_fifo
    import fifo_pkg::*;
#(
    parameter int ALMOST_FULL_OFFSET  = 2,
    parameter int ALMOST_EMPTY_OFFSET = 2
) (
    // ******************************
    // write side
    // ******************************
    input  logic       i_wclk,
    input  logic       i_wrstn,
    input  logic       i_wr,
    input  data_t      i_wdata,
    output wr_status_t o_wstatus,

    // ******************************
    // read side
    // ******************************
    input  logic       i_rclk,
    input  logic       i_rrstn,
    input  logic       i_rd,
    output data_t      o_rdata,
    output rd_status_t o_rstatus
);

    // memory write port
    logic  wen;
    addr_t waddr;
    // memory read address
    addr_t raddr;

    // gray pointers between the two clock domains
    // each side double-flops what it receives
    ptr_t  wgray;
    ptr_t  rgray;

    // storage, written on the write clock, read without a clock
    fifo_mem u_mem (
        .i_wclk  (i_wclk),
        .i_wen   (wen),
        .i_waddr (waddr),
        .i_wdata (i_wdata),
        .i_raddr (raddr),
        .o_rdata (o_rdata)
    );

    // write domain: pointer, full, fill, almost_full
    fifo_wr_ctrl #(
        .ALMOST_FULL_OFFSET (ALMOST_FULL_OFFSET)
    ) u_wr_ctrl (
        .i_wclk    (i_wclk),
        .i_wrstn   (i_wrstn),
        .i_wr      (i_wr),
        .i_rgray   (rgray),
        .o_wen     (wen),
        .o_waddr   (waddr),
        .o_wgray   (wgray),
        .o_wstatus (o_wstatus)
    );

    // read domain: pointer, empty, fill, almost_empty
    fifo_rd_ctrl #(
        .ALMOST_EMPTY_OFFSET (ALMOST_EMPTY_OFFSET)
    ) u_rd_ctrl (
        .i_rclk    (i_rclk),
        .i_rrstn   (i_rrstn),
        .i_rd      (i_rd),
        .i_wgray   (wgray),
        .o_raddr   (raddr),
        .o_rgray   (rgray),
        .o_rstatus (o_rstatus)
    );

endmodule

//--- design/fifo_rd_ctrl.sv
`timescale 1ns/1ns

module fifo_rd_ctrl
    import fifo_pkg::*;
#(
    // almost_empty stays high up to this many words
    parameter int ALMOST_EMPTY_OFFSET = 2
) (
    input  logic       i_rclk,
    input  logic       i_rrstn,
    // read strobe from the consumer
    input  logic       i_rd,
    // write pointer, still in the write clock domain
    input  ptr_t       i_wgray,
    // memory read address
    output addr_t      o_raddr,
    // read pointer toward the write side
    output ptr_t       o_rgray,
    output rd_status_t o_rstatus
);

    // binary read pointer with wrap bit
    ptr_t rbin;
    ptr_t rbin_next;
    ptr_t rgray_next;

    // write pointer synchronizer stages
    ptr_t rq1_wgray;
    ptr_t rq2_wgray;
    ptr_t wbin_sync;

    // next status values
    ptr_t rfill_next;
    logic rempty_next;
    logic ralmost_next;
    logic rd_accept;

    // ******************************
    // write pointer crossing
    // ******************************

    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            rq1_wgray <= '0;
            rq2_wgray <= '0;
        end else begin
            rq1_wgray <= i_wgray;
            rq2_wgray <= rq1_wgray;
        end
    end

    assign wbin_sync = gray2bin(rq2_wgray);

    // ******************************
    // read pointer
    // ******************************

    // a read while empty is dropped here
    assign rd_accept  = i_rd && !o_rstatus.empty;
    assign rbin_next  = rbin + ptr_t'(rd_accept);
    assign rgray_next = bin2gray(rbin_next);

    // registered pointer drives the address
    // so read data steps to the next word one edge after the read
    assign o_raddr = rbin[FIFO_PTR_W-1:0];

    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            rbin    <= '0;
            o_rgray <= '0;
        end else begin
            rbin    <= rbin_next;
            o_rgray <= rgray_next;
        end
    end

    // ******************************
    // status
    // ******************************

    // empty once the read pointer catches the synchronized write pointer
    assign rempty_next = (rgray_next == rq2_wgray);

    // stale write pointer can only make this smaller than the real count
    assign rfill_next = wbin_sync - rbin_next;

    assign ralmost_next = (rfill_next <= ptr_t'(ALMOST_EMPTY_OFFSET));

    // empty sets at the read edge, clears only after the write crossed over
    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            o_rstatus <= '{empty: 1'b1, almost_empty: 1'b1, fill: '0};
        end else begin
            o_rstatus <= '{empty: rempty_next, almost_empty: ralmost_next, fill: rfill_next};
        end
    end

endmodule

//--- design/fifo_wr_ctrl.sv
`timescale 1ns/1ns

module fifo_wr_ctrl
    import fifo_pkg::*;
#(
    // almost_full rises this many words below full
    parameter int ALMOST_FULL_OFFSET = 2
) (
    input  logic       i_wclk,
    input  logic       i_wrstn,
    // write strobe from the producer
    input  logic       i_wr,
    // read pointer, still in the read clock domain
    input  ptr_t       i_rgray,
    // memory write port
    output logic       o_wen,
    output addr_t      o_waddr,
    // write pointer toward the read side
    output ptr_t       o_wgray,
    output wr_status_t o_wstatus
);

    // binary write pointer with wrap bit
    ptr_t wbin;
    ptr_t wbin_next;
    ptr_t wgray_next;

    // read pointer synchronizer stages
    ptr_t wq1_rgray;
    ptr_t wq2_rgray;
    // synchronized read pointer back in binary
    ptr_t rbin_sync;

    // next status values
    ptr_t wfill_next;
    logic wfull_next;
    logic walmost_next;

    // ******************************
    // read pointer crossing
    // ******************************

    // two flops in the write domain
    // gray code keeps every sample within one step of the truth
    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            wq1_rgray <= '0;
            wq2_rgray <= '0;
        end else begin
            wq1_rgray <= i_rgray;
            wq2_rgray <= wq1_rgray;
        end
    end

    assign rbin_sync = gray2bin(wq2_rgray);

    // ******************************
    // write pointer
    // ******************************

    // a write while full is dropped here
    assign o_wen      = i_wr && !o_wstatus.full;
    assign wbin_next  = wbin + ptr_t'(o_wen);
    assign wgray_next = bin2gray(wbin_next);

    // low bits address the memory, wrap bit only tells laps apart
    assign o_waddr = wbin[FIFO_PTR_W-1:0];

    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            wbin    <= '0;
            o_wgray <= '0;
        end else begin
            wbin    <= wbin_next;
            o_wgray <= wgray_next;
        end
    end

    // ******************************
    // status
    // ******************************

    // full in gray: top two bits inverted, rest equal
    // i.e. write pointer one whole lap ahead of the read pointer
    assign wfull_next = (wgray_next == {~wq2_rgray[FIFO_PTR_W -: 2],
                                        wq2_rgray[FIFO_PTR_W-2:0]});

    // modulo subtraction, the extra bit lets a full FIFO read as FIFO_DEPTH
    // stale read pointer can only make this larger than the real count
    assign wfill_next = wbin_next - rbin_sync;

    assign walmost_next = (wfill_next >= ptr_t'(FIFO_DEPTH - ALMOST_FULL_OFFSET));

    // all three registered from the same next values
    // a write shows up in the status at its own edge
    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            o_wstatus <= '{full: 1'b0, almost_full: 1'b1, fill: '0};
        end else begin
            o_wstatus <= '{full: wfull_next, almost_full: walmost_next, fill: wfill_next};
        end
    end

endmodule

//--- design/fifo_mem.sv
`timescale 1ns/1ns

module fifo_mem
    import fifo_pkg::*;
(
    // write port, write clock domain
    input  logic  i_wclk,
    input  logic  i_wen,
    input  addr_t i_waddr,
    input  data_t i_wdata,
    // read port, no clock
    input  addr_t i_raddr,
    output data_t o_rdata
);

    // ******************************
    // storage array
    // ******************************

    // plain array so synthesis maps it to distributed ram
    data_t mem [FIFO_DEPTH];

    // write only when the controller says the slot is free
    always_ff @(posedge i_wclk) begin
        if (i_wen) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // show-ahead read
    // head word is visible as soon as the read address points at it
    assign o_rdata = mem[i_raddr];

endmodule

//--- design/fifo_pkg.sv
package fifo_pkg;

    // ******************************
    // sizes
    // ******************************

    // address bits, 16 entries
    localparam int FIFO_PTR_W = 4;
    // bits per stored word
    localparam int FIFO_DATA_W = 8;
    // entry count
    localparam int FIFO_DEPTH = 1 << FIFO_PTR_W;

    // ******************************
    // types
    // ******************************

    typedef logic [FIFO_DATA_W-1:0] data_t;
    typedef logic [FIFO_PTR_W-1:0]  addr_t;
    // address plus wrap bit, also wide enough for a fill of FIFO_DEPTH
    typedef logic [FIFO_PTR_W:0]    ptr_t;

    // write side flags, pessimistic toward full
    typedef struct packed {
        logic full;
        logic almost_full;
        ptr_t fill;
    } wr_status_t;

    // read side flags, pessimistic toward empty
    typedef struct packed {
        logic empty;
        logic almost_empty;
        ptr_t fill;
    } rd_status_t;

    // ******************************
    // gray code helpers
    // ******************************

    // one bit changes per increment, safe to double-flop
    function automatic ptr_t bin2gray(input ptr_t bin);
        return (bin >> 1) ^ bin;
    endfunction

    // msb passes through, each lower bit folds in the bits above it
    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[FIFO_PTR_W] = gray[FIFO_PTR_W];
        for (int i = FIFO_PTR_W - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage
